// ==== common/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;
    localparam int TAPS = 9;
    localparam int LANES = 4;
    localparam int ADD_PASSES = 4;

    localparam int MULT_LATENCY = 2;
    localparam int ADD_LATENCY = 1;

    // the start edge enters MULT, each pass ends one edge after its ready pulse
    // and the edge that leaves FINISH raises the valid pulse
    localparam int CONV_LATENCY = (MULT_LATENCY + 1) + ADD_PASSES * (ADD_LATENCY + 1) + 1;

    localparam logic signed [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    typedef enum logic [2:0] {
        IDLE,
        MULT,
        ACCUM1,
        ACCUM2,
        ACCUM3,
        ACCUM4,
        FINISH
    } conv_state_e;

    typedef enum logic [1:0] {
        ADD_PRODUCTS,
        ADD_PARTIALS,
        ADD_TAIL
    } add_op_e;

    // clamps a wide signed value to Q8.8, the extra top bit flags a clamp
    function automatic logic [DATA_W:0] sat_fix(input logic signed [2*DATA_W-1:0] value);
        logic [DATA_W:0] result;
        if (value > SAT_MAX) begin
            result = {1'b1, SAT_MAX};
        end else if (value < SAT_MIN) begin
            result = {1'b1, SAT_MIN};
        end else begin
            result = {1'b0, value[DATA_W-1:0]};
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== conv_3x3/conv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_control (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_conv_ready,
    input  logic                       i_mult_rdy,
    input  logic                       i_add_rdy,
    output logic                       o_mult_issue,
    output logic                       o_add_issue,
    output conv_pkg::add_op_e          o_add_op,
    output logic [conv_pkg::LANES-1:0] o_lane_en,
    output logic                       o_sat_clr,
    output logic                       o_finish,
    output logic                       o_busy
);
    import conv_pkg::*;

    conv_state_e state;
    conv_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // a pass only ends on its own ready pulse, start is ignored unless idle
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_conv_ready) begin
                    next_state = MULT;
                end
            end
            MULT: begin
                if (i_mult_rdy) begin
                    next_state = ACCUM1;
                end
            end
            ACCUM1: begin
                if (i_add_rdy) begin
                    next_state = ACCUM2;
                end
            end
            ACCUM2: begin
                if (i_add_rdy) begin
                    next_state = ACCUM3;
                end
            end
            ACCUM3: begin
                if (i_add_rdy) begin
                    next_state = ACCUM4;
                end
            end
            ACCUM4: begin
                if (i_add_rdy) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // strobes are registered on the edge that enters the state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mult_issue <= 1'b0;
            o_add_issue <= 1'b0;
            o_add_op <= ADD_PRODUCTS;
            o_lane_en <= '0;
        end else begin
            o_mult_issue <= 1'b0;
            o_add_issue <= 1'b0;
            if (next_state != state) begin
                case (next_state)
                    MULT: begin
                        o_mult_issue <= 1'b1;
                    end
                    ACCUM1: begin
                        o_add_issue <= 1'b1;
                        o_add_op <= ADD_PRODUCTS;
                        o_lane_en <= '1;
                    end
                    ACCUM2: begin
                        o_add_issue <= 1'b1;
                        o_add_op <= ADD_PARTIALS;
                        o_lane_en <= LANES'(2'b11);
                    end
                    ACCUM3: begin
                        o_add_issue <= 1'b1;
                        o_add_op <= ADD_PARTIALS;
                        o_lane_en <= LANES'(1'b1);
                    end
                    ACCUM4: begin
                        o_add_issue <= 1'b1;
                        o_add_op <= ADD_TAIL;
                        o_lane_en <= LANES'(1'b1);
                    end
                    default: begin
                        o_lane_en <= '0;
                    end
                endcase
            end
        end
    end

    assign o_sat_clr = (state == MULT);
    assign o_finish = (state == FINISH);
    assign o_busy = (state != IDLE);

    a_mult_issue_in_state: assert property (@(posedge clk) disable iff (!rst_n)
        o_mult_issue |-> state == MULT);

    a_add_issue_in_state: assert property (@(posedge clk) disable iff (!rst_n)
        o_add_issue |-> state inside {ACCUM1, ACCUM2, ACCUM3, ACCUM4});

    // every ready must answer the issue of the pass that is still open
    a_mult_rdy_pending: assert property (@(posedge clk) disable iff (!rst_n)
        i_mult_rdy |-> state == MULT && $past(o_mult_issue, MULT_LATENCY));

    a_add_rdy_pending: assert property (@(posedge clk) disable iff (!rst_n)
        i_add_rdy |-> state inside {ACCUM1, ACCUM2, ACCUM3, ACCUM4}
            && $past(o_add_issue, ADD_LATENCY));

endmodule

`default_nettype wire

// ==== conv_3x3/conv_mult_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mult_array (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0] i_im,
    input  logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0] i_iw,
    input  logic                                       i_issue,
    output logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0] o_products,
    output logic                                       o_rdy,
    output logic                                       o_sat
);
    import conv_pkg::*;

    logic [TAPS*DATA_W-1:0]  im_q;
    logic [TAPS*DATA_W-1:0]  iw_q;
    logic [TAPS*DATA_W-1:0]  prod_d;
    logic [TAPS-1:0]         tap_sat;
    logic [MULT_LATENCY-1:0] vld_q;

    // first stage captures the window on issue
    always_ff @(posedge clk) begin
        if (i_issue) begin
            im_q <= i_im;
            iw_q <= i_iw;
        end
    end

    for (genvar n = 0; n < TAPS; n++) begin : g_tap
        logic signed [2*DATA_W-1:0] full;
        logic [DATA_W:0]            sat_res;

        assign full = $signed(im_q[n*DATA_W +: DATA_W]) * $signed(iw_q[n*DATA_W +: DATA_W]);

        // the arithmetic shift floors the Q16.16 product back to Q8.8
        assign sat_res = sat_fix(full >>> FRAC_W);
        assign prod_d[n*DATA_W +: DATA_W] = sat_res[DATA_W-1:0];
        assign tap_sat[n] = sat_res[DATA_W];
    end

    // second stage holds the products until the next window has been multiplied
    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            o_products <= prod_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
            o_sat <= 1'b0;
        end else begin
            vld_q <= {vld_q[MULT_LATENCY-2:0], i_issue};
            o_sat <= vld_q[0] & (|tap_sat);
        end
    end

    assign o_rdy = vld_q[MULT_LATENCY-1];

    a_rdy_latency: assert property (@(posedge clk) disable iff (!rst_n)
        i_issue |-> ##MULT_LATENCY o_rdy);

endmodule

`default_nettype wire

// ==== conv_3x3/conv_adder_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_adder_bank (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0] i_products,
    input  logic                                       i_issue,
    input  conv_pkg::add_op_e                          i_op,
    input  logic [conv_pkg::LANES-1:0]                 i_lane_en,
    output logic [conv_pkg::DATA_W-1:0]                o_sum0,
    output logic                                       o_rdy,
    output logic                                       o_sat
);
    import conv_pkg::*;

    logic signed [DATA_W-1:0] prod [TAPS];
    logic signed [DATA_W-1:0] sum_q [LANES];
    logic signed [DATA_W-1:0] sum_d [LANES];
    logic [LANES-1:0]         lane_sat;

    for (genvar n = 0; n < TAPS; n++) begin : g_prod
        assign prod[n] = i_products[n*DATA_W +: DATA_W];
    end

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        logic signed [DATA_W-1:0]   part_a;
        logic signed [DATA_W-1:0]   part_b;
        logic signed [DATA_W-1:0]   op_a;
        logic signed [DATA_W-1:0]   op_b;
        logic signed [2*DATA_W-1:0] wide;
        logic [DATA_W:0]            res;

        // only the lower lanes have a pair of earlier sums to fold
        if (2*k+1 < LANES) begin : g_part
            assign part_a = sum_q[2*k];
            assign part_b = sum_q[2*k+1];
        end else begin : g_no_part
            assign part_a = '0;
            assign part_b = '0;
        end

        always_comb begin
            case (i_op)
                ADD_PARTIALS: begin
                    op_a = part_a;
                    op_b = part_b;
                end
                ADD_TAIL: begin
                    op_a = sum_q[k];
                    op_b = prod[TAPS-1];
                end
                default: begin
                    op_a = prod[2*k];
                    op_b = prod[2*k+1];
                end
            endcase
        end

        assign wide = op_a + op_b;
        assign res = sat_fix(wide);
        assign sum_d[k] = res[DATA_W-1:0];
        assign lane_sat[k] = res[DATA_W];
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < LANES; k++) begin
            if (i_issue && i_lane_en[k]) begin
                sum_q[k] <= sum_d[k];
            end
        end
    end

    // a disabled lane may clamp on stale data, so only enabled lanes count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rdy <= 1'b0;
            o_sat <= 1'b0;
        end else begin
            o_rdy <= i_issue;
            o_sat <= i_issue & (|(lane_sat & i_lane_en));
        end
    end

    assign o_sum0 = sum_q[0];

    a_tail_lane0_only: assert property (@(posedge clk) disable iff (!rst_n)
        (i_issue && i_op == ADD_TAIL) |-> i_lane_en == LANES'(1'b1));

endmodule

`default_nettype wire

// ==== conv_3x3/conv_3x3.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_3x3 (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0] i_im,
    input  logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0] i_iw,
    input  logic                                       i_conv_ready,
    input  logic                                       i_relu_en,
    output logic [conv_pkg::DATA_W-1:0]                o_om,
    output logic                                       o_conv_valid,
    output logic                                       o_overflow
);
    import conv_pkg::*;

    logic                   mult_issue;
    logic                   mult_rdy;
    logic                   mult_sat;
    logic [TAPS*DATA_W-1:0] products;
    logic                   add_issue;
    add_op_e                add_op;
    logic [LANES-1:0]       lane_en;
    logic                   add_rdy;
    logic                   add_sat;
    logic [DATA_W-1:0]      sum0;
    logic                   sat_clr;
    logic                   finish;
    logic                   busy;
    logic                   sat_sticky;
    logic [DATA_W-1:0]      relu_res;

    conv_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_conv_ready (i_conv_ready),
        .i_mult_rdy   (mult_rdy),
        .i_add_rdy    (add_rdy),
        .o_mult_issue (mult_issue),
        .o_add_issue  (add_issue),
        .o_add_op     (add_op),
        .o_lane_en    (lane_en),
        .o_sat_clr    (sat_clr),
        .o_finish     (finish),
        .o_busy       (busy)
    );

    conv_mult_array u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_im       (i_im),
        .i_iw       (i_iw),
        .i_issue    (mult_issue),
        .o_products (products),
        .o_rdy      (mult_rdy),
        .o_sat      (mult_sat)
    );

    conv_adder_bank u_adder (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_products (products),
        .i_issue    (add_issue),
        .i_op       (add_op),
        .i_lane_en  (lane_en),
        .o_sum0     (sum0),
        .o_rdy      (add_rdy),
        .o_sat      (add_sat)
    );

    // a clamp in any pass of the current window sets the flag, a new window clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sat_sticky <= 1'b0;
        end else if (busy) begin
            sat_sticky <= (sat_sticky & ~sat_clr) | mult_sat | add_sat;
        end
    end

    assign relu_res = (i_relu_en && sum0[DATA_W-1]) ? '0 : sum0;

    always_ff @(posedge clk) begin
        if (finish) begin
            o_om <= relu_res;
        end
    end

    // the flag is latched with the result so both hold until the next window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_conv_valid <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            o_conv_valid <= finish;
            if (finish) begin
                o_overflow <= sat_sticky;
            end
        end
    end

    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ##CONV_LATENCY o_conv_valid);

endmodule

`default_nettype wire

// ==== test/conv_3x3_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_3x3_tb;
    import conv_pkg::*;

    localparam int NUM_DIRECTED = 12;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_TESTS = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (CONV_LATENCY + 4) + 100;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [TAPS*DATA_W-1:0] i_im;
    logic [TAPS*DATA_W-1:0] i_iw;
    logic                   i_conv_ready;
    logic                   i_relu_en;
    logic [DATA_W-1:0]      o_om;
    logic                   o_conv_valid;
    logic                   o_overflow;

    logic [DATA_W-1:0] exp_om_q [$];
    logic              exp_ovf_q [$];
    logic [DATA_W-1:0] exp_om;
    logic              exp_ovf;
    logic [DATA_W-1:0] last_om;
    logic              have_result = 1'b0;
    logic [31:0]       lfsr_state = 32'd1;
    int                cycle_count = 0;
    int                start_cycle = 0;
    int                valid_count = 0;

    conv_3x3 UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_im         (i_im),
        .i_iw         (i_iw),
        .i_conv_ready (i_conv_ready),
        .i_relu_en    (i_relu_en),
        .o_om         (o_om),
        .o_conv_valid (o_conv_valid),
        .o_overflow   (o_overflow)
    );

    always #20 clk = ~clk;

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h",
                                      $time, name, expected, actual));
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic take_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // a random value of the given width, sign extended to 16 bits
    function automatic logic [DATA_W-1:0] rand_operand(input int bits);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < bits; i++) begin
            v[i] = take_bit();
        end
        for (int i = bits; i < DATA_W; i++) begin
            v[i] = v[bits-1];
        end
        return v;
    endfunction

    function automatic int pick_width();
        logic [1:0] sel;
        sel[0] = take_bit();
        sel[1] = take_bit();
        case (sel)
            2'd0: return 16;
            2'd1: return 12;
            2'd2: return 10;
            default: return 8;
        endcase
    endfunction

    function automatic logic [TAPS*DATA_W-1:0] all_taps(input logic [DATA_W-1:0] v);
        return {TAPS{v}};
    endfunction

    function automatic logic [TAPS*DATA_W-1:0] single_tap(input int n,
                                                         input logic [DATA_W-1:0] v);
        logic [TAPS*DATA_W-1:0] w;
        w = '0;
        w[n*DATA_W +: DATA_W] = v;
        return w;
    endfunction

    function automatic int as_signed(input logic [DATA_W-1:0] v);
        logic signed [DATA_W-1:0] s;
        s = v;
        return int'(s);
    endfunction

    // top bit marks a clamp to the Q8.8 range
    function automatic logic [DATA_W:0] clip_q88(input int value);
        logic [DATA_W:0] res;
        if (value > 32767) begin
            res = {1'b1, 16'h7fff};
        end else if (value < -32768) begin
            res = {1'b1, 16'h8000};
        end else begin
            res = {1'b0, value[DATA_W-1:0]};
        end
        return res;
    endfunction

    // returns {overflow, result} for one window
    function automatic logic [DATA_W:0] conv_ref(input logic [TAPS*DATA_W-1:0] im,
                                                input logic [TAPS*DATA_W-1:0] iw,
                                                input logic relu);
        int                prod [TAPS];
        int                sum [4];
        int                left;
        int                right;
        int                acc;
        logic              ovf;
        logic [DATA_W:0]   c;
        logic [DATA_W-1:0] result;
        ovf = 1'b0;
        for (int n = 0; n < TAPS; n++) begin
            // arithmetic shift of a signed product rounds toward minus infinity
            c = clip_q88((as_signed(im[n*DATA_W +: DATA_W]) *
                          as_signed(iw[n*DATA_W +: DATA_W])) >>> FRAC_W);
            ovf |= c[DATA_W];
            prod[n] = as_signed(c[DATA_W-1:0]);
        end
        for (int k = 0; k < 4; k++) begin
            c = clip_q88(prod[2*k] + prod[2*k+1]);
            ovf |= c[DATA_W];
            sum[k] = as_signed(c[DATA_W-1:0]);
        end
        c = clip_q88(sum[0] + sum[1]);
        ovf |= c[DATA_W];
        left = as_signed(c[DATA_W-1:0]);
        c = clip_q88(sum[2] + sum[3]);
        ovf |= c[DATA_W];
        right = as_signed(c[DATA_W-1:0]);
        c = clip_q88(left + right);
        ovf |= c[DATA_W];
        acc = as_signed(c[DATA_W-1:0]);
        c = clip_q88(acc + prod[TAPS-1]);
        ovf |= c[DATA_W];
        result = c[DATA_W-1:0];
        if (relu && result[DATA_W-1]) begin
            result = '0;
        end
        return {ovf, result};
    endfunction

    // starts one window and returns once its valid pulse has been seen
    task automatic run_conv(input logic [TAPS*DATA_W-1:0] im, input logic [TAPS*DATA_W-1:0] iw,
                            input logic relu, input logic [DATA_W-1:0] om,
                            input logic ovf, input int extra_strobe_at);
        int prev;
        exp_om_q.push_back(om);
        exp_ovf_q.push_back(ovf);
        prev = valid_count;
        @(posedge clk);
        i_im <= im;
        i_iw <= iw;
        i_relu_en <= relu;
        i_conv_ready <= 1'b1;
        @(posedge clk);
        i_conv_ready <= 1'b0;
        @(negedge clk);
        start_cycle = cycle_count;
        if (extra_strobe_at > 0) begin
            repeat (extra_strobe_at) @(posedge clk);
            i_conv_ready <= 1'b1;
            @(posedge clk);
            i_conv_ready <= 1'b0;
        end
        while (valid_count == prev) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout: the run did not end within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (o_conv_valid) begin
                if (exp_om_q.size() == 0) begin
                    stop_with_error("a valid pulse arrived with no window outstanding");
                end else begin
                    exp_om = exp_om_q.pop_front();
                    exp_ovf = exp_ovf_q.pop_front();
                    check_value("o_om", exp_om, o_om);
                    check_value("o_overflow", exp_ovf, o_overflow);
                    check_value("latency", CONV_LATENCY, cycle_count - start_cycle);
                    last_om = o_om;
                    have_result = 1'b1;
                    valid_count++;
                end
            end else if (have_result) begin
                check_value("o_om hold", last_om, o_om);
            end
        end
    end

    initial begin
        logic [TAPS*DATA_W-1:0] im;
        logic [TAPS*DATA_W-1:0] iw;
        logic [DATA_W:0]        ref_res;
        logic                   relu;
        int                     width;

        rst_n = 1'b0;
        i_conv_ready = 1'b0;
        i_relu_en = 1'b0;
        i_im = '0;
        i_iw = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // identity weights, unit windows and flooring of a tiny negative product
        run_conv(all_taps(16'h0100), single_tap(4, 16'h0100), 1'b0, 16'h0100, 1'b0, 0);
        run_conv(all_taps(16'h0100), all_taps(16'h0100), 1'b0, 16'h0900, 1'b0, 0);
        run_conv(single_tap(0, 16'h0001), single_tap(0, 16'hff80), 1'b0, 16'hffff, 1'b0, 0);
        run_conv(all_taps(16'h0080), all_taps(16'hff00), 1'b0, 16'hfb80, 1'b0, 0);

        // full scale operands clamp, and the next clean window clears the flag
        run_conv(all_taps(16'h7fff), all_taps(16'h7fff), 1'b0, 16'h7fff, 1'b1, 0);
        run_conv(all_taps(16'h0100), all_taps(16'h0100), 1'b0, 16'h0900, 1'b0, 0);
        run_conv(all_taps(16'h7fff), all_taps(16'h8000), 1'b0, 16'h8000, 1'b1, 0);
        run_conv(all_taps(16'h4000), all_taps(16'h0100), 1'b0, 16'h7fff, 1'b1, 0);
        run_conv(all_taps(16'h0100), single_tap(4, 16'h0100), 1'b0, 16'h0100, 1'b0, 0);

        run_conv(all_taps(16'h0080), all_taps(16'hff00), 1'b1, 16'h0000, 1'b0, 0);
        run_conv(all_taps(16'h0100), all_taps(16'h0100), 1'b1, 16'h0900, 1'b0, 0);

        // a second start while busy must not produce another pulse
        run_conv(all_taps(16'h0200), all_taps(16'h0100), 1'b0, 16'h1200, 1'b0, 4);
        repeat (2 * CONV_LATENCY) @(posedge clk);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            width = pick_width();
            for (int n = 0; n < TAPS; n++) begin
                im[n*DATA_W +: DATA_W] = rand_operand(width);
                iw[n*DATA_W +: DATA_W] = rand_operand(width);
            end
            relu = take_bit();
            ref_res = conv_ref(im, iw, relu);
            run_conv(im, iw, relu, ref_res[DATA_W-1:0], ref_res[DATA_W], 0);
        end

        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/conv_pkg.sv
conv_3x3/conv_control.sv
conv_3x3/conv_mult_array.sv
conv_3x3/conv_adder_bank.sv
conv_3x3/conv_3x3.sv
test/conv_3x3_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = conv_3x3_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK
SOURCES   = $(wildcard common/*.sv conv_3x3/*.sv test/*.sv)
BINARY    = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
